// File: filelist.f
+incdir+verif
logic/prs_pkg.sv
logic/ps2_receiver.sv
logic/game_sequencer.sv
logic/message_scanner.sv
logic/prs_game.sv
verif/tb_prs_game.sv

// File: Bender.yml
package:
  name: prs_game

sources:
  - logic/prs_pkg.sv
  - logic/ps2_receiver.sv
  - logic/game_sequencer.sv
  - logic/message_scanner.sv
  - logic/prs_game.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_prs_game.sv

// File: verif/tb_prs_helpers.svh
`ifndef TB_PRS_HELPERS_SVH
`define TB_PRS_HELPERS_SVH

// device side of one PS/2 frame, 8 clk cycles per half period
task automatic send_ps2_byte(input logic [7:0] data);
    logic [10:0] frame;
    frame = {1'b1, ~^data, data, 1'b0}; // stop, odd parity, data, start
    @(posedge clk);
    for (int i = 0; i < ps2_frame_bits; i++) begin
        data_ps2 <= frame[i];
        repeat (8) @(posedge clk);
        clk_ps2 <= 1'b0;
        repeat (8) @(posedge clk);
        clk_ps2 <= 1'b1;
    end
    data_ps2 <= 1'b1;
endtask

// one full scan, turned back into a message
task automatic read_message(output msg_e shown, output bit ok);
    logic [7:0] glyphs [num_digits];
    bit         seen [num_digits];
    bit         clash;
    bit         match;
    int         digit;
    clash = 1'b0;
    ok    = 1'b0;
    shown = msg_start;
    for (int d = 0; d < num_digits; d++) begin
        seen[d]   = 1'b0;
        glyphs[d] = glyph_blank;
    end
    repeat (2 * num_digits) begin
        @(negedge clk); // outputs settled here
        digit = -1;
        for (int k = 0; k < num_digits; k++) begin
            if (an_out == ~(8'b1 << k)) digit = k;
        end
        if (digit < 0) begin
            clash = 1'b1;
        end else if (seen[digit] && glyphs[digit] != c_out) begin
            clash = 1'b1; // message changed mid scan
        end else begin
            seen[digit]   = 1'b1;
            glyphs[digit] = c_out;
        end
    end
    for (int d = 0; d < num_digits; d++) begin
        if (!seen[d]) clash = 1'b1;
    end
    if (!clash) begin
        for (int k = 0; k <= int'(msg_tie); k++) begin
            match = 1'b1;
            for (int d = 0; d < num_digits; d++) begin
                if (msg_glyph(msg_e'(k), 3'(d)) != glyphs[d]) match = 1'b0;
            end
            if (match) begin
                ok    = 1'b1;
                shown = msg_e'(k);
            end
        end
    end
endtask

`endif

// File: verif/tb_prs_game.sv
module tb_prs_game import prs_pkg::*; ();

    localparam int hold_cycles   = 200;
    localparam int num_entries   = 9;
    localparam int timeout_limit = num_entries * (6 * hold_cycles + 2000);

    typedef struct packed {
        logic [1:0] player_random;
        logic [2:0] clicks;
        logic [1:0] rival_random;
        msg_e       exp_player;
        msg_e       exp_verdict;
    } scenario_t;

    logic        clk = 1'b0;
    logic        resetn;
    logic        clk_ps2;
    logic        data_ps2;
    logic [1:0]  random;
    logic [7:0]  an_out;
    logic [7:0]  c_out;
    int unsigned cycle_count = 0;
    msg_e        cur_msg;
    scenario_t   scenarios [num_entries];

    prs_game #(
        .hold_cycles   (hold_cycles),
        .scan_div_bits (1)
    ) u_dut (
        .clk      (clk),
        .resetn   (resetn),
        .clk_ps2  (clk_ps2),
        .data_ps2 (data_ps2),
        .random   (random),
        .an_out   (an_out),
        .c_out    (c_out)
    );

    always #2 clk = ~clk;

    `include "tb_prs_helpers.svh"

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR: %s expected 0x%0h, got 0x%0h", name, expected, actual);
            abort_run("stopping at the first mismatch");
        end
    endtask

    // game rules, as seen on the display
    function automatic msg_e predict_pick(logic [1:0] r);
        case (r)
            2'd0:    return msg_paper;
            2'd1:    return msg_scissors;
            default: return msg_rock;
        endcase
    endfunction

    function automatic msg_e rotate_hand(msg_e h);
        if (h == msg_paper) return msg_scissors;
        if (h == msg_scissors) return msg_rock;
        return msg_paper;
    endfunction

    function automatic msg_e predict_verdict(msg_e p, msg_e r);
        if (p == r) return msg_tie;
        if ((p == msg_paper && r == msg_rock) || (p == msg_scissors && r == msg_paper) ||
            (p == msg_rock && r == msg_scissors)) return msg_win;
        return msg_lose;
    endfunction

    function automatic scenario_t make_scenario(logic [1:0] pr, int clicks, logic [1:0] rr);
        scenario_t s;
        msg_e      hand;
        hand = predict_pick(pr);
        repeat (clicks) hand = rotate_hand(hand);
        s.player_random = pr;
        s.clicks        = 3'(clicks);
        s.rival_random  = rr;
        s.exp_player    = hand;
        s.exp_verdict   = predict_verdict(hand, predict_pick(rr));
        return s;
    endfunction

    // poll the display until it leaves the current message
    task automatic expect_message(input msg_e expected);
        msg_e seen;
        msg_e shown;
        bit   ok;
        int   misses;
        misses = 0;
        shown  = cur_msg;
        while (shown == cur_msg) begin
            read_message(seen, ok);
            if (!ok) begin
                misses++;
                if (misses >= 2) abort_run("display shows no known message");
            end else begin
                misses = 0;
                shown  = seen;
            end
        end
        check_value("msg", expected, shown);
        cur_msg = shown;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            abort_run("timeout: the game rounds did not finish in time");
        end
    end

    initial begin
        msg_e      shown;
        msg_e      hand;
        bit        ok;
        scenario_t s;
        resetn   = 1'b0;
        clk_ps2  = 1'b1; // PS/2 lines idle high
        data_ps2 = 1'b1;
        random   = 2'd0;
        scenarios[0] = make_scenario(2'd0, 0, 2'd0); // paper, paper
        scenarios[1] = make_scenario(2'd0, 1, 2'd0); // scissors, paper
        scenarios[2] = make_scenario(2'd3, 0, 2'd0); // rock, paper
        scenarios[3] = make_scenario(2'd1, 2, 2'd1); // paper, scissors
        scenarios[4] = make_scenario(2'd1, 0, 2'd1); // scissors, scissors
        scenarios[5] = make_scenario(2'd2, 0, 2'd1); // rock, scissors
        scenarios[6] = make_scenario(2'd2, 1, 2'd2); // paper, rock
        scenarios[7] = make_scenario(2'd0, 4, 2'd3); // scissors, rock
        scenarios[8] = make_scenario(2'd1, 1, 2'd2); // rock, rock
        repeat (16) begin
            @(negedge clk);
            check_value("an_out", 8'hff, an_out); // dark during reset
        end
        @(posedge clk);
        resetn <= 1'b1;
        repeat (2) @(posedge clk);
        read_message(shown, ok);
        if (!ok) abort_run("display shows no known message after reset");
        check_value("msg", msg_start, shown);
        cur_msg = shown;
        for (int i = 0; i < num_entries; i++) begin
            s = scenarios[i];
            @(posedge clk);
            random <= s.player_random;
            expect_message(msg_select);
            hand = predict_pick(s.player_random);
            expect_message(hand);
            for (int c = 0; c < s.clicks; c++) begin
                send_ps2_byte(8'h04);
                hand = rotate_hand(hand);
                expect_message(hand);
            end
            check_value("msg", s.exp_player, cur_msg);
            @(posedge clk);
            random <= s.rival_random;
            send_ps2_byte((i % 2 == 1) ? 8'h06 : 8'h02); // odd rows press both buttons
            expect_message(msg_rival);
            send_ps2_byte(8'h04); // rival phase must ignore it
            expect_message(predict_pick(s.rival_random));
            expect_message(s.exp_verdict);
            expect_message(msg_start);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: logic/prs_game.sv
module prs_game import prs_pkg::*; #(
    parameter int unsigned hold_cycles   = 80000001,
    parameter int unsigned scan_div_bits = 18
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       clk_ps2,
    input  logic       data_ps2,
    input  logic [1:0] random,
    output logic [7:0] an_out,
    output logic [7:0] c_out
);

    logic         event_valid;
    mouse_event_t mouse_event;
    msg_e         msg;
    seg_drive_t   seg;

    ps2_receiver u_receiver (
        .clk         (clk),
        .resetn      (resetn),
        .clk_ps2     (clk_ps2),
        .data_ps2    (data_ps2),
        .event_valid (event_valid),
        .mouse_event (mouse_event)
    );

    game_sequencer #(
        .hold_cycles (hold_cycles)
    ) u_sequencer (
        .clk         (clk),
        .resetn      (resetn),
        .random      (random),
        .event_valid (event_valid),
        .mouse_event (mouse_event),
        .msg         (msg)
    );

    message_scanner #(
        .scan_div_bits (scan_div_bits)
    ) u_scanner (
        .clk    (clk),
        .resetn (resetn),
        .msg    (msg),
        .seg    (seg)
    );

    assign an_out = seg.an;
    assign c_out  = seg.c;

endmodule

// File: logic/message_scanner.sv
module message_scanner import prs_pkg::*; #(
    parameter int unsigned scan_div_bits = 18
) (
    input  logic       clk,
    input  logic       resetn,
    input  msg_e       msg,
    output seg_drive_t seg
);

    logic [scan_div_bits+2:0] scan_cnt;
    logic [2:0]               digit;

    assign digit = scan_cnt[scan_div_bits+2 -: 3]; // top three bits pick the digit

    always_ff @(posedge clk) begin
        if (!resetn) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // registered drive, one cycle behind the counter
    always_ff @(posedge clk) begin
        if (!resetn) begin
            seg.an <= '1; // all digits dark
            seg.c  <= glyph_blank;
        end else begin
            seg.an <= ~({{(num_digits-1){1'b0}}, 1'b1} << digit);
            seg.c  <= msg_glyph(msg, digit);
        end
    end

    a_one_anode: assert property (@(posedge clk) disable iff (!resetn)
        $past(resetn) |-> $onehot(~seg.an));

endmodule

// File: logic/game_sequencer.sv
module game_sequencer import prs_pkg::*; #(
    parameter int unsigned hold_cycles = 80000001
) (
    input  logic         clk,
    input  logic         resetn,
    input  logic [1:0]   random,
    input  logic         event_valid,
    input  mouse_event_t mouse_event,
    output msg_e         msg
);

    game_state_e state;
    logic [31:0] timer;
    logic        timed;
    logic        phase_done;
    hand_e       player_hand;
    hand_e       rival_hand;

    assign timed = (state != st_choose); // choose waits for the mouse
    assign phase_done = timed && (timer == 32'(hold_cycles - 1));

    // phase timer, zero on the first cycle of every phase
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer <= '0;
        end else if (phase_done || !timed) begin
            timer <= '0;
        end else begin
            timer <= timer + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= st_start;
            player_hand <= hand_paper;
            rival_hand  <= hand_paper;
        end else begin
            case (state)
                st_start: begin
                    if (phase_done) begin
                        state <= st_select;
                    end
                end
                st_select: begin
                    if (phase_done) begin
                        state       <= st_choose;
                        player_hand <= hand_from_random(random);
                    end
                end
                st_choose: begin
                    if (event_valid && mouse_event.confirm) begin
                        state <= st_rival; // confirm wins over advance
                    end else if (event_valid && mouse_event.advance) begin
                        player_hand <= next_hand(player_hand);
                    end
                end
                st_rival: begin
                    if (phase_done) begin
                        state      <= st_reveal;
                        rival_hand <= hand_from_random(random);
                    end
                end
                st_reveal: begin
                    if (phase_done) begin
                        state <= st_verdict;
                    end
                end
                st_verdict: begin
                    if (phase_done) begin
                        state <= st_start;
                    end
                end
                default: begin
                    state <= st_start;
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            st_start:   msg = msg_start;
            st_select:  msg = msg_select;
            st_choose:  msg = hand_msg(player_hand);
            st_rival:   msg = msg_rival;
            st_reveal:  msg = hand_msg(rival_hand);
            st_verdict: msg = judge(player_hand, rival_hand);
            default:    msg = msg_start;
        endcase
    end

    // random value 3 must have been folded onto rock
    a_hand_legal: assert property (@(posedge clk) disable iff (!resetn)
        (player_hand != 2'd3) && (rival_hand != 2'd3));

endmodule

// File: logic/ps2_receiver.sv
module ps2_receiver import prs_pkg::*; (
    input  logic         clk,
    input  logic         resetn,
    input  logic         clk_ps2,
    input  logic         data_ps2,
    output logic         event_valid,
    output mouse_event_t mouse_event
);

    logic       clk_meta, clk_sync, clk_last;
    logic       data_meta, data_sync, data_last;
    logic       fall_q;
    logic [3:0] bit_cnt;
    logic [7:0] data_byte;
    logic       frame_done;

    // both lines idle high, so reset to 1 to avoid a false edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            clk_meta  <= 1'b1;
            clk_sync  <= 1'b1;
            clk_last  <= 1'b1;
            data_meta <= 1'b1;
            data_sync <= 1'b1;
            data_last <= 1'b1;
            fall_q    <= 1'b0;
        end else begin
            clk_meta  <= clk_ps2;
            clk_sync  <= clk_meta;
            clk_last  <= clk_sync;
            data_meta <= data_ps2;
            data_sync <= data_meta;
            data_last <= data_sync; // lines up with fall_q
            fall_q    <= clk_last & ~clk_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= fall_q && (bit_cnt == 4'd9);
            if (fall_q) begin
                if (bit_cnt == 4'(ps2_frame_bits - 1)) begin
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (fall_q && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            data_byte <= {data_last, data_byte[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            event_valid <= 1'b0;
        end else begin
            event_valid <= frame_done; // third cycle after the bit 9 edge
        end
    end

    always_ff @(posedge clk) begin
        if (frame_done) begin
            mouse_event.confirm <= data_byte[1];
            mouse_event.advance <= data_byte[2];
        end
    end

    a_bit_cnt_range: assert property (@(posedge clk) disable iff (!resetn)
        bit_cnt <= 4'(ps2_frame_bits - 1));

endmodule

// File: logic/prs_pkg.sv
package prs_pkg;

    localparam int num_digits = 8;
    localparam int ps2_frame_bits = 11;

    typedef enum logic [2:0] {
        st_start,
        st_select,
        st_choose,
        st_rival,
        st_reveal,
        st_verdict
    } game_state_e;

    typedef enum logic [1:0] {
        hand_paper    = 2'd0,
        hand_scissors = 2'd1,
        hand_rock     = 2'd2
    } hand_e;

    typedef enum logic [3:0] {
        msg_start,
        msg_select,
        msg_paper,
        msg_scissors,
        msg_rock,
        msg_rival,
        msg_win,
        msg_lose,
        msg_tie
    } msg_e;

    typedef struct packed {
        logic advance; // middle button, data bit 2
        logic confirm; // right button, data bit 1
    } mouse_event_t;

    typedef struct packed {
        logic [num_digits-1:0] an; // digit select, active low
        logic [7:0]            c;  // segments, active low
    } seg_drive_t;

    // cathode patterns, bit 7 is the decimal point
    localparam logic [7:0] glyph_blank = 8'hff;
    localparam logic [7:0] glyph_a = 8'b10001000;
    localparam logic [7:0] glyph_c = 8'b11000110;
    localparam logic [7:0] glyph_e = 8'b10000110;
    localparam logic [7:0] glyph_i = 8'b11001111;
    localparam logic [7:0] glyph_k = 8'b10001010;
    localparam logic [7:0] glyph_l = 8'b11000111;
    localparam logic [7:0] glyph_n = 8'b10101011;
    localparam logic [7:0] glyph_o = 8'b10100011;
    localparam logic [7:0] glyph_p = 8'b10001100;
    localparam logic [7:0] glyph_r = 8'b10101111;
    localparam logic [7:0] glyph_s = 8'b11010010;
    localparam logic [7:0] glyph_t = 8'b10000111;
    localparam logic [7:0] glyph_u = 8'b11100011;
    localparam logic [7:0] glyph_v = 8'b11010101;
    localparam logic [7:0] glyph_w = 8'b10010101;
    localparam logic [7:0] glyph_y = 8'b10010001;

    typedef logic [num_digits-1:0][7:0] msg_text_t;

    // written left to right as seen on the board, digit 0 is rightmost
    localparam msg_text_t text_start = {glyph_blank, glyph_blank, glyph_blank,
        glyph_s, glyph_t, glyph_a, glyph_r, glyph_t};
    localparam msg_text_t text_select = {glyph_blank, glyph_blank,
        glyph_s, glyph_e, glyph_l, glyph_e, glyph_c, glyph_t};
    localparam msg_text_t text_paper = {glyph_blank, glyph_blank, glyph_blank,
        glyph_p, glyph_a, glyph_p, glyph_e, glyph_r};
    localparam msg_text_t text_scissors = {glyph_s, glyph_c, glyph_i, glyph_s,
        glyph_s, glyph_o, glyph_r, glyph_s};
    localparam msg_text_t text_rock = {glyph_blank, glyph_blank, glyph_blank,
        glyph_blank, glyph_r, glyph_o, glyph_c, glyph_k};
    localparam msg_text_t text_rival = {glyph_blank, glyph_blank, glyph_blank,
        glyph_r, glyph_i, glyph_v, glyph_a, glyph_l};
    localparam msg_text_t text_win = {glyph_blank, glyph_y, glyph_o, glyph_u,
        glyph_blank, glyph_w, glyph_o, glyph_n};
    localparam msg_text_t text_lose = {glyph_y, glyph_o, glyph_u, glyph_blank,
        glyph_l, glyph_o, glyph_s, glyph_t};
    localparam msg_text_t text_tie = {glyph_blank, glyph_blank, glyph_blank,
        glyph_blank, glyph_blank, glyph_t, glyph_i, glyph_e};

    function automatic logic [7:0] msg_glyph(msg_e m, logic [2:0] digit);
        case (m)
            msg_start:    return text_start[digit];
            msg_select:   return text_select[digit];
            msg_paper:    return text_paper[digit];
            msg_scissors: return text_scissors[digit];
            msg_rock:     return text_rock[digit];
            msg_rival:    return text_rival[digit];
            msg_win:      return text_win[digit];
            msg_lose:     return text_lose[digit];
            msg_tie:      return text_tie[digit];
            default:      return glyph_blank;
        endcase
    endfunction

    function automatic hand_e hand_from_random(logic [1:0] r);
        case (r)
            2'd0:    return hand_paper;
            2'd1:    return hand_scissors;
            default: return hand_rock; // 3 folds onto rock
        endcase
    endfunction

    function automatic hand_e next_hand(hand_e h);
        case (h)
            hand_paper:    return hand_scissors;
            hand_scissors: return hand_rock;
            default:       return hand_paper;
        endcase
    endfunction

    function automatic msg_e judge(hand_e player, hand_e rival);
        if (player == rival) begin
            return msg_tie;
        end
        if ((player == hand_paper && rival == hand_rock) ||
            (player == hand_scissors && rival == hand_paper) ||
            (player == hand_rock && rival == hand_scissors)) begin
            return msg_win;
        end
        return msg_lose;
    endfunction

    function automatic msg_e hand_msg(hand_e h);
        case (h)
            hand_paper:    return msg_paper;
            hand_scissors: return msg_scissors;
            default:       return msg_rock;
        endcase
    endfunction

endpackage
